/* rv_defs.svh */
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

////////////////////
// Core widths
////////////////////

// Data path and program counter width
`define RV_XLEN 32

// Register address width
`define RV_REG_BITS 5

// Architectural integer registers, x0 included
`define RV_NUM_REGS 32

`endif

/* rv_pkg.sv */
package rv_pkg;

  // Major opcodes handled by the core, anything else is illegal
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_BRANCH = 7'b1100011
  } opcode_e;

  // ALU operations, PASS_B forwards operand B for LUI
  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_SLL    = 4'd2,
    ALU_SLT    = 4'd3,
    ALU_SLTU   = 4'd4,
    ALU_XOR    = 4'd5,
    ALU_SRL    = 4'd6,
    ALU_SRA    = 4'd7,
    ALU_OR     = 4'd8,
    ALU_AND    = 4'd9,
    ALU_PASS_B = 4'd10
  } alu_op_e;

  // Branch conditions, same codes as funct3
  typedef enum logic [2:0] {
    BR_BEQ  = 3'b000,
    BR_BNE  = 3'b001,
    BR_BLT  = 3'b100,
    BR_BGE  = 3'b101,
    BR_BLTU = 3'b110,
    BR_BGEU = 3'b111
  } br_cond_e;

endpackage

/* rv_decode.sv */
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_decode import rv_pkg::*; (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    instr_valid_i,
  input  logic [31:0]             instr_i,
  input  logic [`RV_XLEN-1:0]     instr_pc_i,
  output logic                    instr_ready_o,
  input  logic                    ret_accept_i,
  output logic                    dec_valid_o,
  output logic [`RV_XLEN-1:0]     dec_pc_o,
  output logic [`RV_REG_BITS-1:0] dec_rs1_o,
  output logic [`RV_REG_BITS-1:0] dec_rs2_o,
  output logic [`RV_REG_BITS-1:0] dec_rd_o,
  output logic                    dec_we_o,
  output logic                    dec_use_imm_o,
  output logic [`RV_XLEN-1:0]     dec_imm_o,
  output alu_op_e                 dec_alu_op_o,
  output logic                    dec_branch_o,
  output br_cond_e                dec_br_cond_o,
  output logic                    dec_illegal_o
);

  logic [2:0]          funct3;
  logic [6:0]          funct7;
  logic                f7_zero;
  logic                f7_alt;
  logic [`RV_XLEN-1:0] imm_i_type;
  logic [`RV_XLEN-1:0] imm_u_type;
  logic [`RV_XLEN-1:0] imm_b_type;

  logic                d_we;
  logic                d_use_imm;
  logic [`RV_XLEN-1:0] d_imm;
  alu_op_e             d_alu_op;
  logic                d_branch;
  br_cond_e            d_br_cond;
  logic                d_illegal;

  assign funct3  = instr_i[14:12];
  assign funct7  = instr_i[31:25];
  assign f7_zero = (funct7 == 7'b0000000);
  assign f7_alt  = (funct7 == 7'b0100000);

  assign imm_i_type = {{(`RV_XLEN-12){instr_i[31]}}, instr_i[31:20]};
  assign imm_u_type = {instr_i[31:12], 12'b0};
  assign imm_b_type = {{(`RV_XLEN-13){instr_i[31]}}, instr_i[31], instr_i[7],
                       instr_i[30:25], instr_i[11:8], 1'b0};

  ////////////////////
  // Field decode
  ////////////////////

  always_comb begin
    d_we      = 1'b0;
    d_use_imm = 1'b0;
    d_imm     = imm_i_type;
    d_alu_op  = ALU_ADD;
    d_branch  = 1'b0;
    d_br_cond = BR_BEQ;
    d_illegal = 1'b0;
    case (opcode_e'(instr_i[6:0]))
      OPC_OP, OPC_OP_IMM: begin
        d_use_imm = (instr_i[6:0] == OPC_OP_IMM);
        case (funct3)
          3'b000: d_alu_op = (!d_use_imm && f7_alt) ? ALU_SUB : ALU_ADD;
          3'b001: d_alu_op = ALU_SLL;
          3'b010: d_alu_op = ALU_SLT;
          3'b011: d_alu_op = ALU_SLTU;
          3'b100: d_alu_op = ALU_XOR;
          3'b101: d_alu_op = f7_alt ? ALU_SRA : ALU_SRL;
          3'b110: d_alu_op = ALU_OR;
          default: d_alu_op = ALU_AND;
        endcase
        // funct7 only matters for shifts and for register ADD/SUB
        if (!d_use_imm || funct3 == 3'b001 || funct3 == 3'b101) begin
          if (!(f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101)))) begin
            d_illegal = 1'b1;
          end
        end
        d_we = !d_illegal;
      end
      OPC_LUI: begin
        d_use_imm = 1'b1;
        d_imm     = imm_u_type;
        d_alu_op  = ALU_PASS_B;
        d_we      = 1'b1;
      end
      OPC_BRANCH: begin
        d_imm     = imm_b_type;
        d_alu_op  = ALU_SUB;
        d_br_cond = br_cond_e'(funct3);
        // funct3 010 and 011 are not branch conditions
        d_illegal = (funct3[2:1] == 2'b01);
        d_branch  = !d_illegal;
      end
      default: d_illegal = 1'b1;
    endcase
  end

  ////////////////////
  // One-entry register
  ////////////////////

  assign instr_ready_o = !dec_valid_o || ret_accept_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      dec_valid_o <= 1'b0;
    end else if (instr_ready_o) begin
      dec_valid_o <= instr_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (instr_valid_i && instr_ready_o) begin
      dec_pc_o      <= instr_pc_i;
      dec_rs1_o     <= instr_i[19:15];
      dec_rs2_o     <= instr_i[24:20];
      dec_rd_o      <= instr_i[11:7];
      // No write for x0 destinations
      dec_we_o      <= d_we && (instr_i[11:7] != '0);
      dec_use_imm_o <= d_use_imm;
      dec_imm_o     <= d_imm;
      dec_alu_op_o  <= d_alu_op;
      dec_branch_o  <= d_branch;
      dec_br_cond_o <= d_br_cond;
      dec_illegal_o <= d_illegal;
    end
  end

endmodule

/* rv_regfile.sv */
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_regfile import rv_pkg::*; (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic [`RV_REG_BITS-1:0] rs1_addr_i,
  input  logic [`RV_REG_BITS-1:0] rs2_addr_i,
  input  logic [`RV_REG_BITS-1:0] rd_addr_i,
  input  logic                    write_i,
  input  logic [`RV_XLEN-1:0]     data_i,
  output logic [`RV_XLEN-1:0]     rs1_o,
  output logic [`RV_XLEN-1:0]     rs2_o
);

  logic [`RV_XLEN-1:0] regs [`RV_NUM_REGS];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (write_i && rd_addr_i != '0) begin
      regs[rd_addr_i] <= data_i;
    end
  end

  // x0 is hardwired to zero
  assign rs1_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
  assign rs2_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

/* rv_alu.sv */
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_alu import rv_pkg::*; (
  input  alu_op_e             op_i,
  input  logic [`RV_XLEN-1:0] a_i,
  input  logic [`RV_XLEN-1:0] b_i,
  output logic [`RV_XLEN-1:0] result_o,
  output logic                equal_o,
  output logic                less_o,
  output logic                less_signed_o
);

  logic [4:0] shamt;

  // Shifts only look at the low five bits
  assign shamt = b_i[4:0];

  ////////////////////
  // Compare flags
  ////////////////////

  assign equal_o       = (a_i == b_i);
  assign less_o        = (a_i < b_i);
  assign less_signed_o = ($signed(a_i) < $signed(b_i));

  ////////////////////
  // Result select
  ////////////////////

  always_comb begin
    case (op_i)
      ALU_ADD:    result_o = a_i + b_i;
      ALU_SUB:    result_o = a_i - b_i;
      ALU_SLL:    result_o = a_i << shamt;
      ALU_SLT:    result_o = {{(`RV_XLEN-1){1'b0}}, less_signed_o};
      ALU_SLTU:   result_o = {{(`RV_XLEN-1){1'b0}}, less_o};
      ALU_XOR:    result_o = a_i ^ b_i;
      ALU_SRL:    result_o = a_i >> shamt;
      ALU_SRA:    result_o = $unsigned($signed(a_i) >>> shamt);
      ALU_OR:     result_o = a_i | b_i;
      ALU_AND:    result_o = a_i & b_i;
      ALU_PASS_B: result_o = b_i;
      default:    result_o = '0;
    endcase
  end

endmodule

/* rv_execute.sv */
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_execute import rv_pkg::*; (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic [`RV_XLEN-1:0]     dec_pc_i,
  input  logic [`RV_REG_BITS-1:0] dec_rs1_i,
  input  logic [`RV_REG_BITS-1:0] dec_rs2_i,
  input  logic                    dec_use_imm_i,
  input  logic [`RV_XLEN-1:0]     dec_imm_i,
  input  alu_op_e                 dec_alu_op_i,
  input  logic                    dec_branch_i,
  input  br_cond_e                dec_br_cond_i,
  input  logic                    fwd_valid_i,
  input  logic                    fwd_we_i,
  input  logic [`RV_REG_BITS-1:0] fwd_rd_i,
  input  logic [`RV_XLEN-1:0]     fwd_data_i,
  input  logic                    rf_write_i,
  input  logic [`RV_REG_BITS-1:0] rf_rd_i,
  input  logic [`RV_XLEN-1:0]     rf_data_i,
  output logic [`RV_XLEN-1:0]     ex_result_o,
  output logic                    ex_branch_taken_o,
  output logic [`RV_XLEN-1:0]     ex_branch_target_o
);

  logic [`RV_XLEN-1:0] rf_rs1;
  logic [`RV_XLEN-1:0] rf_rs2;
  logic                fwd_hit;
  logic [`RV_XLEN-1:0] src1;
  logic [`RV_XLEN-1:0] src2;
  logic [`RV_XLEN-1:0] op_a;
  logic [`RV_XLEN-1:0] op_b;
  logic                alu_equal;
  logic                alu_less;
  logic                alu_less_signed;
  logic                cond_met;

  rv_regfile regfile0 (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .rs1_addr_i (dec_rs1_i),
    .rs2_addr_i (dec_rs2_i),
    .rd_addr_i  (rf_rd_i),
    .write_i    (rf_write_i),
    .data_i     (rf_data_i),
    .rs1_o      (rf_rs1),
    .rs2_o      (rf_rs2)
  );

  // Retire record not yet written back takes priority over the file
  assign fwd_hit = fwd_valid_i && fwd_we_i && (fwd_rd_i != '0);
  assign src1    = (fwd_hit && fwd_rd_i == dec_rs1_i) ? fwd_data_i : rf_rs1;
  assign src2    = (fwd_hit && fwd_rd_i == dec_rs2_i) ? fwd_data_i : rf_rs2;

  // LUI carries immediate bits in the rs1 field
  assign op_a = (dec_alu_op_i == ALU_PASS_B) ? '0 : src1;
  assign op_b = dec_use_imm_i ? dec_imm_i : src2;

  rv_alu alu0 (
    .op_i          (dec_alu_op_i),
    .a_i           (op_a),
    .b_i           (op_b),
    .result_o      (ex_result_o),
    .equal_o       (alu_equal),
    .less_o        (alu_less),
    .less_signed_o (alu_less_signed)
  );

  always_comb begin
    case (dec_br_cond_i)
      BR_BEQ:  cond_met = alu_equal;
      BR_BNE:  cond_met = !alu_equal;
      BR_BLT:  cond_met = alu_less_signed;
      BR_BGE:  cond_met = !alu_less_signed;
      BR_BLTU: cond_met = alu_less;
      BR_BGEU: cond_met = !alu_less;
      default: cond_met = 1'b0;
    endcase
  end

  assign ex_branch_taken_o  = dec_branch_i && cond_met;
  assign ex_branch_target_o = dec_pc_i + dec_imm_i;

endmodule

/* rv_retire.sv */
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_retire import rv_pkg::*; (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    dec_valid_i,
  input  logic [`RV_XLEN-1:0]     dec_pc_i,
  input  logic [`RV_REG_BITS-1:0] dec_rd_i,
  input  logic                    dec_we_i,
  input  logic                    dec_illegal_i,
  input  logic [`RV_XLEN-1:0]     ex_result_i,
  input  logic                    ex_branch_taken_i,
  input  logic [`RV_XLEN-1:0]     ex_branch_target_i,
  input  logic                    retire_ready_i,
  output logic                    ret_accept_o,
  output logic                    rf_write_o,
  output logic                    retire_valid_o,
  output logic [`RV_XLEN-1:0]     retire_pc_o,
  output logic [`RV_REG_BITS-1:0] retire_rd_o,
  output logic                    retire_we_o,
  output logic [`RV_XLEN-1:0]     retire_data_o,
  output logic                    retire_branch_taken_o,
  output logic [`RV_XLEN-1:0]     retire_branch_target_o,
  output logic                    retire_illegal_o
);

  // Room for a new record when empty or when the current one leaves
  assign ret_accept_o = !retire_valid_o || retire_ready_i;

  // Register file is written as the record leaves the core
  assign rf_write_o = retire_valid_o && retire_ready_i && retire_we_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      retire_valid_o <= 1'b0;
    end else if (ret_accept_o) begin
      retire_valid_o <= dec_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (dec_valid_i && ret_accept_o) begin
      retire_pc_o            <= dec_pc_i;
      retire_rd_o            <= dec_rd_i;
      retire_we_o            <= dec_we_i;
      // Data reads zero for records that do not write
      retire_data_o          <= dec_we_i ? ex_result_i : '0;
      retire_branch_taken_o  <= ex_branch_taken_i;
      retire_branch_target_o <= ex_branch_target_i;
      retire_illegal_o       <= dec_illegal_i;
    end
  end

endmodule

/* rv_core.sv */
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_core import rv_pkg::*; (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    instr_valid_i,
  input  logic [31:0]             instr_i,
  input  logic [`RV_XLEN-1:0]     instr_pc_i,
  output logic                    instr_ready_o,
  output logic                    retire_valid_o,
  output logic [`RV_XLEN-1:0]     retire_pc_o,
  output logic [`RV_REG_BITS-1:0] retire_rd_o,
  output logic                    retire_we_o,
  output logic [`RV_XLEN-1:0]     retire_data_o,
  output logic                    retire_branch_taken_o,
  output logic [`RV_XLEN-1:0]     retire_branch_target_o,
  output logic                    retire_illegal_o,
  input  logic                    retire_ready_i
);

  logic                    ret_accept;
  logic                    rf_write;
  logic                    dec_valid;
  logic [`RV_XLEN-1:0]     dec_pc;
  logic [`RV_REG_BITS-1:0] dec_rs1;
  logic [`RV_REG_BITS-1:0] dec_rs2;
  logic [`RV_REG_BITS-1:0] dec_rd;
  logic                    dec_we;
  logic                    dec_use_imm;
  logic [`RV_XLEN-1:0]     dec_imm;
  alu_op_e                 dec_alu_op;
  logic                    dec_branch;
  br_cond_e                dec_br_cond;
  logic                    dec_illegal;
  logic [`RV_XLEN-1:0]     ex_result;
  logic                    ex_branch_taken;
  logic [`RV_XLEN-1:0]     ex_branch_target;

  ////////////////////
  // Input side
  ////////////////////

  rv_decode decode0 (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .instr_pc_i    (instr_pc_i),
    .instr_ready_o (instr_ready_o),
    .ret_accept_i  (ret_accept),
    .dec_valid_o   (dec_valid),
    .dec_pc_o      (dec_pc),
    .dec_rs1_o     (dec_rs1),
    .dec_rs2_o     (dec_rs2),
    .dec_rd_o      (dec_rd),
    .dec_we_o      (dec_we),
    .dec_use_imm_o (dec_use_imm),
    .dec_imm_o     (dec_imm),
    .dec_alu_op_o  (dec_alu_op),
    .dec_branch_o  (dec_branch),
    .dec_br_cond_o (dec_br_cond),
    .dec_illegal_o (dec_illegal)
  );

  ////////////////////
  // Execute
  ////////////////////

  rv_execute execute0 (
    .clk_i              (clk_i),
    .reset_i            (reset_i),
    .dec_pc_i           (dec_pc),
    .dec_rs1_i          (dec_rs1),
    .dec_rs2_i          (dec_rs2),
    .dec_use_imm_i      (dec_use_imm),
    .dec_imm_i          (dec_imm),
    .dec_alu_op_i       (dec_alu_op),
    .dec_branch_i       (dec_branch),
    .dec_br_cond_i      (dec_br_cond),
    .fwd_valid_i        (retire_valid_o),
    .fwd_we_i           (retire_we_o),
    .fwd_rd_i           (retire_rd_o),
    .fwd_data_i         (retire_data_o),
    .rf_write_i         (rf_write),
    .rf_rd_i            (retire_rd_o),
    .rf_data_i          (retire_data_o),
    .ex_result_o        (ex_result),
    .ex_branch_taken_o  (ex_branch_taken),
    .ex_branch_target_o (ex_branch_target)
  );

  ////////////////////
  // Output side
  ////////////////////

  rv_retire retire0 (
    .clk_i                  (clk_i),
    .reset_i                (reset_i),
    .dec_valid_i            (dec_valid),
    .dec_pc_i               (dec_pc),
    .dec_rd_i               (dec_rd),
    .dec_we_i               (dec_we),
    .dec_illegal_i          (dec_illegal),
    .ex_result_i            (ex_result),
    .ex_branch_taken_i      (ex_branch_taken),
    .ex_branch_target_i     (ex_branch_target),
    .retire_ready_i         (retire_ready_i),
    .ret_accept_o           (ret_accept),
    .rf_write_o             (rf_write),
    .retire_valid_o         (retire_valid_o),
    .retire_pc_o            (retire_pc_o),
    .retire_rd_o            (retire_rd_o),
    .retire_we_o            (retire_we_o),
    .retire_data_o          (retire_data_o),
    .retire_branch_taken_o  (retire_branch_taken_o),
    .retire_branch_target_o (retire_branch_target_o),
    .retire_illegal_o       (retire_illegal_o)
  );

endmodule

/* rv_core_sva.sv */
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_core_sva (
  input logic                    clk_i,
  input logic                    reset_i,
  input logic                    retire_valid_i,
  input logic                    retire_ready_i,
  input logic [`RV_XLEN-1:0]     retire_pc_i,
  input logic [`RV_REG_BITS-1:0] retire_rd_i,
  input logic                    retire_we_i,
  input logic [`RV_XLEN-1:0]     retire_data_i,
  input logic                    retire_branch_taken_i,
  input logic [`RV_XLEN-1:0]     retire_branch_target_i,
  input logic                    retire_illegal_i
);

  ////////////////////
  // Output handshake
  ////////////////////

  // A stalled record stays put until the consumer takes it
  assert property (@(posedge clk_i) disable iff (reset_i)
    retire_valid_i && !retire_ready_i |=> retire_valid_i && $stable(retire_pc_i) &&
      $stable(retire_rd_i) && $stable(retire_we_i) && $stable(retire_data_i) &&
      $stable(retire_branch_taken_i) && $stable(retire_branch_target_i) &&
      $stable(retire_illegal_i))
    else $error("retire record changed or dropped while stalled");

  assert property (@(posedge clk_i) reset_i |=> !retire_valid_i)
    else $error("retire_valid_o high right after reset");

endmodule

bind rv_core rv_core_sva sva0 (
  .clk_i                  (clk_i),
  .reset_i                (reset_i),
  .retire_valid_i         (retire_valid_o),
  .retire_ready_i         (retire_ready_i),
  .retire_pc_i            (retire_pc_o),
  .retire_rd_i            (retire_rd_o),
  .retire_we_i            (retire_we_o),
  .retire_data_i          (retire_data_o),
  .retire_branch_taken_i  (retire_branch_taken_o),
  .retire_branch_target_i (retire_branch_target_o),
  .retire_illegal_i       (retire_illegal_o)
);

/* tb_rv_core.sv */
`timescale 1ns/1ps
`include "rv_defs.svh"

module tb_rv_core;

  localparam int NUM_INSTR        = 800;
  localparam int CYCLES_PER_INSTR = 10;
  localparam int CYCLE_NS         = 20;

  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;

  typedef struct packed {
    logic [31:0] pc;
    logic [4:0]  rd;
    logic        we;
    logic [31:0] data;
    logic        taken;
    logic        branch;
    logic [31:0] target;
    logic        illegal;
    logic [31:0] cycle;
  } retire_rec_t;

  logic                    clk_i;
  logic                    reset_i;
  logic                    instr_valid_i;
  logic [31:0]             instr_i;
  logic [`RV_XLEN-1:0]     instr_pc_i;
  logic                    instr_ready_o;
  logic                    retire_valid_o;
  logic [`RV_XLEN-1:0]     retire_pc_o;
  logic [`RV_REG_BITS-1:0] retire_rd_o;
  logic                    retire_we_o;
  logic [`RV_XLEN-1:0]     retire_data_o;
  logic                    retire_branch_taken_o;
  logic [`RV_XLEN-1:0]     retire_branch_target_o;
  logic                    retire_illegal_o;
  logic                    retire_ready_i;

  logic [31:0] lfsr_state;
  logic [31:0] model_rf [32];
  retire_rec_t exp_q [$];
  logic [31:0] pc_next;
  logic [4:0]  last_rd;
  int          cycle_cnt;
  int          generated;
  int          accepted;
  int          test_errors;
  int          total_errors;
  int          check_count;
  int          tests_run;
  int          tests_failed;
  bit          chk_latency;

  rv_core dut0 (
    .clk_i                  (clk_i),
    .reset_i                (reset_i),
    .instr_valid_i          (instr_valid_i),
    .instr_i                (instr_i),
    .instr_pc_i             (instr_pc_i),
    .instr_ready_o          (instr_ready_o),
    .retire_valid_o         (retire_valid_o),
    .retire_pc_o            (retire_pc_o),
    .retire_rd_o            (retire_rd_o),
    .retire_we_o            (retire_we_o),
    .retire_data_o          (retire_data_o),
    .retire_branch_taken_o  (retire_branch_taken_o),
    .retire_branch_target_o (retire_branch_target_o),
    .retire_illegal_o       (retire_illegal_o),
    .retire_ready_i         (retire_ready_i)
  );

  always #10 clk_i = ~clk_i;

  ////////////////////
  // Random source
  ////////////////////

  function automatic logic rand_bit();
    lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
    return lfsr_state[0];
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val = {val[30:0], rand_bit()};
    end
    return val;
  endfunction

  // Mode 0 ALU, 1 dependent ALU, 2 branch, 3 everything, 4 illegal mix
  function automatic logic [31:0] make_instr(input int mode);
    logic [2:0]  kind;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [11:0] imm;
    logic [12:0] bimm;
    logic [6:0]  opc;
    logic        alt;
    logic [31:0] ins;
    kind = 3'(rand_bits(2) % 3);
    if (mode == 2) begin
      kind = 3'd3;
    end else if (mode == 3) begin
      kind = 3'(rand_bits(3) % 5);
    end else if (mode == 4 && rand_bit()) begin
      kind = 3'd4;
    end
    rd  = 5'(rand_bits(3));
    rs1 = 5'(rand_bits(3));
    rs2 = 5'(rand_bits(3));
    // Chain on the previous destination so forwarding is exercised
    if (mode == 1) begin
      rs1 = last_rd;
      if (rand_bit()) begin
        rs2 = last_rd;
      end
    end
    f3  = 3'(rand_bits(3));
    imm = 12'(rand_bits(12));
    alt = rand_bit();
    case (kind)
      3'd0: ins = {(alt && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00, rs2, rs1, f3, rd, OP_REG};
      3'd1: begin
        if (f3 == 3'd1) begin
          imm[11:5] = 7'h00;
        end
        if (f3 == 3'd5) begin
          imm[11:5] = alt ? 7'h20 : 7'h00;
        end
        ins = {imm, rs1, f3, rd, OP_IMM};
      end
      3'd2: ins = {20'(rand_bits(20)), rd, OP_LUI};
      3'd3: begin
        if (f3[2:1] == 2'b01) begin
          f3[1] = 1'b0;
        end
        bimm = {imm, 1'b0};
        ins  = {bimm[12], bimm[10:5], rs2, rs1, f3, bimm[4:1], bimm[11], OP_BRANCH};
      end
      default: begin
        opc = {5'(rand_bits(5)), 2'b11};
        if (opc == OP_REG || opc == OP_IMM || opc == OP_LUI || opc == OP_BRANCH) begin
          opc = 7'b0000011;
        end
        if (alt) begin
          ins = {7'h00, rs2, rs1, 2'b01, f3[0], rd, OP_BRANCH};
        end else begin
          ins = {imm, rs1, f3, rd, opc};
        end
      end
    endcase
    last_rd = rd;
    return ins;
  endfunction

  ////////////////////
  // Reference model
  ////////////////////

  task automatic predict(input logic [31:0] ins, input logic [31:0] pc);
    retire_rec_t rec;
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    opc = ins[6:0];
    f3  = ins[14:12];
    a   = model_rf[ins[19:15]];
    b   = (opc == OP_REG) ? model_rf[ins[24:20]] : {{20{ins[31]}}, ins[31:20]};
    res = '0;
    rec = '0;
    rec.pc    = pc;
    rec.rd    = ins[11:7];
    rec.cycle = cycle_cnt;
    if (opc == OP_REG || opc == OP_IMM) begin
      rec.we = 1'b1;
      case (f3)
        3'd0: res = (opc == OP_REG && ins[30]) ? a - b : a + b;
        3'd1: res = a << b[4:0];
        3'd2: res = {31'b0, $signed(a) < $signed(b)};
        3'd3: res = {31'b0, a < b};
        3'd4: res = a ^ b;
        3'd5: begin
          if (ins[30]) begin
            res = $unsigned($signed(a) >>> b[4:0]);
          end else begin
            res = a >> b[4:0];
          end
        end
        3'd6: res = a | b;
        default: res = a & b;
      endcase
    end else if (opc == OP_LUI) begin
      rec.we = 1'b1;
      res    = {ins[31:12], 12'b0};
    end else if (opc == OP_BRANCH && f3[2:1] != 2'b01) begin
      b          = model_rf[ins[24:20]];
      rec.branch = 1'b1;
      rec.target = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
      case (f3)
        3'b000: rec.taken = (a == b);
        3'b001: rec.taken = (a != b);
        3'b100: rec.taken = ($signed(a) < $signed(b));
        3'b101: rec.taken = ($signed(a) >= $signed(b));
        3'b110: rec.taken = (a < b);
        default: rec.taken = (a >= b);
      endcase
    end else begin
      rec.illegal = 1'b1;
    end
    rec.we   = rec.we && (rec.rd != 5'd0);
    rec.data = rec.we ? res : 32'd0;
    if (rec.we) begin
      model_rf[rec.rd] = res;
    end
    exp_q.push_back(rec);
  endtask

  ////////////////////
  // Scoreboard
  ////////////////////

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    check_count++;
    assert (act === exp) else begin
      $display("CHECK FAILED at %0t: %s expected 0x%08h, got 0x%08h", $time, name, exp, act);
      test_errors++;
    end
  endtask

  task automatic compare_record();
    retire_rec_t rec;
    assert (exp_q.size() != 0) else begin
      $display("ERROR at %0t: retire record with no instruction outstanding", $time);
      test_errors++;
    end
    if (exp_q.size() != 0) begin
      rec = exp_q.pop_front();
      check_value("retire_pc_o", rec.pc, retire_pc_o);
      check_value("retire_rd_o", 32'(rec.rd), 32'(retire_rd_o));
      check_value("retire_we_o", 32'(rec.we), 32'(retire_we_o));
      check_value("retire_data_o", rec.data, retire_data_o);
      check_value("retire_branch_taken_o", 32'(rec.taken), 32'(retire_branch_taken_o));
      check_value("retire_illegal_o", 32'(rec.illegal), 32'(retire_illegal_o));
      if (rec.branch) begin
        check_value("retire_branch_target_o", rec.target, retire_branch_target_o);
      end
      if (chk_latency) begin
        check_value("retire latency", 32'd2, 32'(cycle_cnt) - rec.cycle);
      end
    end
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  // Sample at the falling edge, drive at the next rising edge
  task automatic step_cycle(input int mode, input int count, input bit rand_valid,
                            input bit rand_ready);
    logic        in_fire;
    logic        out_fire;
    logic        nxt_valid;
    logic [31:0] nxt_instr;
    logic [31:0] nxt_pc;
    logic        nxt_ready;
    @(negedge clk_i);
    in_fire  = instr_valid_i && instr_ready_o;
    out_fire = retire_valid_o && retire_ready_i;
    if (out_fire) begin
      compare_record();
    end
    if (in_fire) begin
      predict(instr_i, instr_pc_i);
      accepted++;
    end
    assert (exp_q.size() <= 2) else begin
      $display("ERROR at %0t: more than two instructions in flight", $time);
      test_errors++;
    end
    cycle_cnt++;
    nxt_valid = instr_valid_i;
    nxt_instr = instr_i;
    nxt_pc    = instr_pc_i;
    if (!instr_valid_i || in_fire) begin
      nxt_valid = 1'b0;
      if (generated < count && (!rand_valid || rand_bit())) begin
        nxt_valid = 1'b1;
        nxt_instr = make_instr(mode);
        nxt_pc    = pc_next;
        pc_next   = pc_next + 32'd4;
        generated++;
      end
    end
    nxt_ready = rand_ready ? rand_bit() : 1'b1;
    @(posedge clk_i);
    instr_valid_i  <= nxt_valid;
    instr_i        <= nxt_instr;
    instr_pc_i     <= nxt_pc;
    retire_ready_i <= nxt_ready;
  endtask

  task automatic finish_test(input string name, input int count);
    $display("%-12s %0d instructions, %0d errors", name, count, test_errors);
    total_errors += test_errors;
    tests_run++;
    if (test_errors != 0) begin
      tests_failed++;
    end
  endtask

  task automatic run_test(input string name, input int mode, input int count,
                          input bit rand_valid, input bit rand_ready);
    test_errors = 0;
    generated   = 0;
    accepted    = 0;
    chk_latency = !rand_ready;
    while (accepted < count || exp_q.size() != 0) begin
      step_cycle(mode, count, rand_valid, rand_ready);
    end
    finish_test(name, count);
  endtask

  initial begin
    clk_i          = 1'b0;
    reset_i        = 1'b1;
    instr_valid_i  = 1'b0;
    instr_i        = '0;
    instr_pc_i     = '0;
    retire_ready_i = 1'b1;
    lfsr_state     = 32'd81;
    pc_next        = 32'h0000_1000;
    last_rd        = '0;
    cycle_cnt      = 0;
    total_errors   = 0;
    check_count    = 0;
    tests_run      = 0;
    tests_failed   = 0;
    for (int i = 0; i < 32; i++) begin
      model_rf[i] = '0;
    end
    repeat (3) @(posedge clk_i);
    reset_i <= 1'b0;

    test_errors = 0;
    @(negedge clk_i);
    check_value("retire_valid_o", 32'd0, 32'(retire_valid_o));
    check_value("instr_ready_o", 32'd1, 32'(instr_ready_o));
    finish_test("reset", 0);

    run_test("alu", 0, 200, 1'b0, 1'b0);
    run_test("forwarding", 1, 100, 1'b0, 1'b0);
    run_test("branch", 2, 100, 1'b0, 1'b0);
    run_test("backpressure", 3, 300, 1'b1, 1'b1);
    run_test("illegal", 4, 100, 1'b0, 1'b1);

    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, check_count, total_errors);
    if (total_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // Generous bound on the run from the total instruction count
  initial begin
    #(NUM_INSTR * CYCLES_PER_INSTR * CYCLE_NS);
    $display("Timeout: the core stopped retiring before all tests finished");
    $display("Testbench failed");
    $finish;
  end

endmodule

/* project.f */
+incdir+.
rv_pkg.sv
rv_decode.sv
rv_regfile.sv
rv_alu.sv
rv_execute.sv
rv_retire.sv
rv_core.sv
rv_core_sva.sv
tb_rv_core.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator, pass only if the pass line shows up
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_rv_core -f project.f || exit 1
out="$(./obj_dir/Vtb_rv_core)"
echo "$out"
echo "$out" | grep -qx "Testbench passed" && exit 0 || exit 1
